//--- logic/bus86_pkg.sv
package bus86_pkg;

	////////////////////////////////////////////////////////////////////////////
	// CPU and bus widths
	////////////////////////////////////////////////////////////////////////////

	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0]  cpu_data_t;

	// Shared video bus carries A12..A0 only
	typedef logic [12:0] bus_addr_t;

	// Program ROM window is 32K
	typedef logic [14:0] rom_addr_t;

	// Chip select on the shared bus
	typedef enum logic [2:0] {
		SEL_NONE    = 3'd0,
		SEL_SCROLL0 = 3'd1,
		SEL_SCROLL1 = 3'd2,
		SEL_OBJECT  = 3'd3,
		SEL_LATCH0  = 3'd4,
		SEL_LATCH1  = 3'd5
	} bus_sel_e;

	////////////////////////////////////////////////////////////////////////////
	// Local register window, 0x7000..0x7FFF
	////////////////////////////////////////////////////////////////////////////

	typedef logic [11:0] loc_ofs_t;

	// Master only
	localparam loc_ofs_t OFS_BANK      = 12'h000;
	localparam loc_ofs_t OFS_BACKCOLOR = 12'h400;

	// Both CPUs, clears the writer's vblank irq
	localparam loc_ofs_t OFS_IRQ_ACK   = 12'h800;

endpackage

//--- logic/cpu_port.sv
`timescale 1ns/10ps

module cpu_port import bus86_pkg::*; (
	input  logic      clk_6m,
	input  logic      rst_n,

	input  logic      req_valid,
	output logic      req_ready,
	input  cpu_addr_t req_addr,
	input  logic      req_we,
	input  cpu_data_t req_wdata,
	output logic      resp_valid,
	output cpu_data_t resp_rdata,

	output logic      rom_en,
	output rom_addr_t rom_addr,
	input  cpu_data_t rom_data,

	output logic      sh_valid,
	output bus_addr_t sh_addr,
	output bus_sel_e  sh_sel,
	output logic      sh_we,
	output cpu_data_t sh_wdata,
	input  logic      sh_grant,
	input  logic      sh_rvalid,
	input  cpu_data_t sh_rdata,

	output logic      loc_access,
	output logic      loc_we,
	output loc_ofs_t  loc_ofs,
	output cpu_data_t loc_wdata,
	input  cpu_data_t loc_rdata
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_LOC,
		ST_ROM0,
		ST_ROM1,
		ST_SH,
		ST_SH_RD
	} state_e;

	state_e    state;
	cpu_addr_t addr_q;
	logic      we_q;
	cpu_data_t wdata_q;

	// Memory map decode for the shared bus windows
	function automatic bus_sel_e decode_sel(input cpu_addr_t a);
		bus_sel_e sel;
		sel = SEL_NONE;
		if (a[15:13] == 3'd0)
			sel = SEL_SCROLL0;
		else if (a[15:13] == 3'd1)
			sel = SEL_SCROLL1;
		else if (a[15:13] == 3'd2)
			sel = SEL_OBJECT;
		else if (a[15:11] == 5'b01100)
			sel = SEL_LATCH0;
		else if (a[15:11] == 5'b01101)
			sel = SEL_LATCH1;
		return sel;
	endfunction

	// Region picks the first sequencer state
	function automatic state_e first_state(input cpu_addr_t a);
		state_e st;
		if (a[15])
			st = ST_ROM0;
		else if (a[15:12] == 4'h7)
			st = ST_LOC;
		else
			st = ST_SH;
		return st;
	endfunction

	// Held request
	always_ff @(posedge clk_6m) begin
		if (req_valid && req_ready) begin
			addr_q  <= req_addr;
			we_q    <= req_we;
			wdata_q <= req_wdata;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			state      <= ST_IDLE;
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= 1'b0;
			case (state)
				ST_IDLE:
					if (req_valid)
						state <= first_state(req_addr);
				ST_LOC, ST_ROM1: begin
					resp_valid <= 1'b1;
					state      <= ST_IDLE;
				end
				ST_ROM0:
					state <= ST_ROM1;
				ST_SH:
					if (sh_grant) begin
						// writes finish on the handshake itself
						if (we_q) begin
							resp_valid <= 1'b1;
							state      <= ST_IDLE;
						end else begin
							state <= ST_SH_RD;
						end
					end
				ST_SH_RD:
					if (sh_rvalid) begin
						resp_valid <= 1'b1;
						state      <= ST_IDLE;
					end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Response byte, writes answer 0
	always_ff @(posedge clk_6m) begin
		case (state)
			ST_LOC:   resp_rdata <= we_q ? '0 : loc_rdata;
			ST_ROM1:  resp_rdata <= we_q ? '0 : rom_data;
			ST_SH:    if (sh_grant) resp_rdata <= '0;
			ST_SH_RD: if (sh_rvalid) resp_rdata <= sh_rdata;
			default:  ;
		endcase
	end

	assign req_ready = (state == ST_IDLE);

	// ROM writes never reach the ROM
	assign rom_en   = (state == ST_ROM0) && !we_q;
	assign rom_addr = addr_q[14:0];

	assign sh_valid = (state == ST_SH);
	assign sh_addr  = addr_q[12:0];
	assign sh_sel   = decode_sel(addr_q);
	assign sh_we    = we_q;
	assign sh_wdata = wdata_q;

	assign loc_access = (state == ST_LOC);
	assign loc_we     = we_q;
	assign loc_ofs    = addr_q[11:0];
	assign loc_wdata  = wdata_q;

endmodule

//--- logic/ctrl_regs.sv
`timescale 1ns/10ps

module ctrl_regs import bus86_pkg::*; (
	input  logic      clk_6m,
	input  logic      rst_n,
	input  logic      vblank_n,

	input  logic      m_loc_access,
	input  logic      m_loc_we,
	input  loc_ofs_t  m_loc_ofs,
	input  cpu_data_t m_loc_wdata,
	output cpu_data_t m_loc_rdata,

	input  logic      s_loc_access,
	input  logic      s_loc_we,
	input  loc_ofs_t  s_loc_ofs,
	input  cpu_data_t s_loc_wdata,
	output cpu_data_t s_loc_rdata,

	output logic      rom_bank,
	output cpu_data_t backcolor,
	output logic      irq_m,
	output logic      irq_s
);

	logic vblank_q;
	logic vblank_fall;
	logic m_wr;
	logic s_wr;
	logic m_ack;
	logic s_ack;

	assign vblank_fall = vblank_q && !vblank_n;

	assign m_wr  = m_loc_access && m_loc_we;
	assign s_wr  = s_loc_access && s_loc_we;
	assign m_ack = m_wr && (m_loc_ofs == OFS_IRQ_ACK);
	assign s_ack = s_wr && (s_loc_ofs == OFS_IRQ_ACK);

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			vblank_q  <= 1'b1;
			rom_bank  <= 1'b0;
			backcolor <= '0;
			irq_m     <= 1'b0;
			irq_s     <= 1'b0;
		end else begin
			vblank_q <= vblank_n;

			// Bank and back colour respond to the master only
			if (m_wr && m_loc_ofs == OFS_BANK)
				rom_bank <= m_loc_wdata[0];
			if (m_wr && m_loc_ofs == OFS_BACKCOLOR)
				backcolor <= m_loc_wdata;

			// A new vblank wins over an ack in the same cycle
			if (vblank_fall)
				irq_m <= 1'b1;
			else if (m_ack)
				irq_m <= 1'b0;
			if (vblank_fall)
				irq_s <= 1'b1;
			else if (s_ack)
				irq_s <= 1'b0;
		end
	end

	always_comb begin
		m_loc_rdata = '0;
		if (m_loc_access && !m_loc_we) begin
			if (m_loc_ofs == OFS_BANK)
				m_loc_rdata = {7'd0, rom_bank};
			else if (m_loc_ofs == OFS_BACKCOLOR)
				m_loc_rdata = backcolor;
		end
	end

	// Nothing readable on the sub side
	assign s_loc_rdata = '0;

endmodule

//--- logic/slot_arbiter.sv
`timescale 1ns/10ps

module slot_arbiter import bus86_pkg::*; (
	input  logic      clk_6m,
	input  logic      rst_n,

	input  logic      m_sh_valid,
	input  bus_addr_t m_sh_addr,
	input  bus_sel_e  m_sh_sel,
	input  logic      m_sh_we,
	input  cpu_data_t m_sh_wdata,
	output logic      m_sh_grant,
	output logic      m_sh_rvalid,
	output cpu_data_t m_sh_rdata,

	input  logic      s_sh_valid,
	input  bus_addr_t s_sh_addr,
	input  bus_sel_e  s_sh_sel,
	input  logic      s_sh_we,
	input  cpu_data_t s_sh_wdata,
	output logic      s_sh_grant,
	output logic      s_sh_rvalid,
	output cpu_data_t s_sh_rdata,

	output logic      bus_valid,
	input  logic      bus_ready,
	output bus_addr_t bus_addr,
	output bus_sel_e  bus_sel,
	output logic      bus_we,
	output cpu_data_t bus_wdata,
	output logic      bus_cpu,
	input  cpu_data_t bus_rdata
);

	// 2H phase, 0 is the master's slot
	logic slot;
	logic handshake;
	logic rd_pend;
	logic rd_cpu;

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n)
			slot <= 1'b0;
		else
			slot <= !slot;
	end

	////////////////////////////////////////////////////////////////////////////
	// Bus drive from the slot owner
	////////////////////////////////////////////////////////////////////////////

	assign bus_cpu   = slot;
	assign bus_valid = slot ? s_sh_valid : m_sh_valid;
	assign bus_addr  = slot ? s_sh_addr : m_sh_addr;
	assign bus_sel   = !bus_valid ? SEL_NONE : (slot ? s_sh_sel : m_sh_sel);
	assign bus_we    = bus_valid && (slot ? s_sh_we : m_sh_we);
	assign bus_wdata = slot ? s_sh_wdata : m_sh_wdata;

	assign handshake  = bus_valid && bus_ready;
	assign m_sh_grant = handshake && !slot;
	assign s_sh_grant = handshake && slot;

	// Read return, data arrives the cycle after the handshake
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			rd_pend     <= 1'b0;
			rd_cpu      <= 1'b0;
			m_sh_rvalid <= 1'b0;
			s_sh_rvalid <= 1'b0;
		end else begin
			rd_pend     <= handshake && !bus_we;
			rd_cpu      <= slot;
			m_sh_rvalid <= rd_pend && !rd_cpu;
			s_sh_rvalid <= rd_pend && rd_cpu;
		end
	end

	always_ff @(posedge clk_6m) begin
		if (rd_pend && !rd_cpu)
			m_sh_rdata <= bus_rdata;
		if (rd_pend && rd_cpu)
			s_sh_rdata <= bus_rdata;
	end

endmodule

//--- logic/bus86_top.sv
`timescale 1ns/10ps

module bus86_top import bus86_pkg::*; (
	input  logic      clk_6m,
	input  logic      rst_n,
	input  logic      vblank_n,

	// Master CPU
	input  logic      m_req_valid,
	output logic      m_req_ready,
	input  cpu_addr_t m_req_addr,
	input  logic      m_req_we,
	input  cpu_data_t m_req_wdata,
	output logic      m_resp_valid,
	output cpu_data_t m_resp_rdata,

	// Sub CPU
	input  logic      s_req_valid,
	output logic      s_req_ready,
	input  cpu_addr_t s_req_addr,
	input  logic      s_req_we,
	input  cpu_data_t s_req_wdata,
	output logic      s_resp_valid,
	output cpu_data_t s_resp_rdata,

	// Program ROMs
	output logic      mrom_en,
	output rom_addr_t mrom_addr,
	output logic      mrom_bank,
	input  cpu_data_t mrom_data,
	output logic      srom_en,
	output rom_addr_t srom_addr,
	input  cpu_data_t srom_data,

	// Shared video bus
	output logic      bus_valid,
	input  logic      bus_ready,
	output bus_addr_t bus_addr,
	output bus_sel_e  bus_sel,
	output logic      bus_we,
	output cpu_data_t bus_wdata,
	output logic      bus_cpu,
	input  cpu_data_t bus_rdata,

	output logic      irq_m,
	output logic      irq_s,
	output cpu_data_t backcolor
);

	logic      m_sh_valid;
	bus_addr_t m_sh_addr;
	bus_sel_e  m_sh_sel;
	logic      m_sh_we;
	cpu_data_t m_sh_wdata;
	logic      m_sh_grant;
	logic      m_sh_rvalid;
	cpu_data_t m_sh_rdata;
	logic      m_loc_access;
	logic      m_loc_we;
	loc_ofs_t  m_loc_ofs;
	cpu_data_t m_loc_wdata;
	cpu_data_t m_loc_rdata;

	logic      s_sh_valid;
	bus_addr_t s_sh_addr;
	bus_sel_e  s_sh_sel;
	logic      s_sh_we;
	cpu_data_t s_sh_wdata;
	logic      s_sh_grant;
	logic      s_sh_rvalid;
	cpu_data_t s_sh_rdata;
	logic      s_loc_access;
	logic      s_loc_we;
	loc_ofs_t  s_loc_ofs;
	cpu_data_t s_loc_wdata;
	cpu_data_t s_loc_rdata;

	cpu_port port_m (
		.clk_6m(clk_6m), .rst_n(rst_n),
		.req_valid(m_req_valid), .req_ready(m_req_ready), .req_addr(m_req_addr),
		.req_we(m_req_we), .req_wdata(m_req_wdata),
		.resp_valid(m_resp_valid), .resp_rdata(m_resp_rdata),
		.rom_en(mrom_en), .rom_addr(mrom_addr), .rom_data(mrom_data),
		.sh_valid(m_sh_valid), .sh_addr(m_sh_addr), .sh_sel(m_sh_sel),
		.sh_we(m_sh_we), .sh_wdata(m_sh_wdata), .sh_grant(m_sh_grant),
		.sh_rvalid(m_sh_rvalid), .sh_rdata(m_sh_rdata),
		.loc_access(m_loc_access), .loc_we(m_loc_we), .loc_ofs(m_loc_ofs),
		.loc_wdata(m_loc_wdata), .loc_rdata(m_loc_rdata)
	);

	cpu_port port_s (
		.clk_6m(clk_6m), .rst_n(rst_n),
		.req_valid(s_req_valid), .req_ready(s_req_ready), .req_addr(s_req_addr),
		.req_we(s_req_we), .req_wdata(s_req_wdata),
		.resp_valid(s_resp_valid), .resp_rdata(s_resp_rdata),
		.rom_en(srom_en), .rom_addr(srom_addr), .rom_data(srom_data),
		.sh_valid(s_sh_valid), .sh_addr(s_sh_addr), .sh_sel(s_sh_sel),
		.sh_we(s_sh_we), .sh_wdata(s_sh_wdata), .sh_grant(s_sh_grant),
		.sh_rvalid(s_sh_rvalid), .sh_rdata(s_sh_rdata),
		.loc_access(s_loc_access), .loc_we(s_loc_we), .loc_ofs(s_loc_ofs),
		.loc_wdata(s_loc_wdata), .loc_rdata(s_loc_rdata)
	);

	// Bank bit goes straight to the master ROM
	ctrl_regs regs0 (
		.clk_6m(clk_6m), .rst_n(rst_n), .vblank_n(vblank_n),
		.m_loc_access(m_loc_access), .m_loc_we(m_loc_we), .m_loc_ofs(m_loc_ofs),
		.m_loc_wdata(m_loc_wdata), .m_loc_rdata(m_loc_rdata),
		.s_loc_access(s_loc_access), .s_loc_we(s_loc_we), .s_loc_ofs(s_loc_ofs),
		.s_loc_wdata(s_loc_wdata), .s_loc_rdata(s_loc_rdata),
		.rom_bank(mrom_bank), .backcolor(backcolor),
		.irq_m(irq_m), .irq_s(irq_s)
	);

	slot_arbiter arb0 (
		.clk_6m(clk_6m), .rst_n(rst_n),
		.m_sh_valid(m_sh_valid), .m_sh_addr(m_sh_addr), .m_sh_sel(m_sh_sel),
		.m_sh_we(m_sh_we), .m_sh_wdata(m_sh_wdata), .m_sh_grant(m_sh_grant),
		.m_sh_rvalid(m_sh_rvalid), .m_sh_rdata(m_sh_rdata),
		.s_sh_valid(s_sh_valid), .s_sh_addr(s_sh_addr), .s_sh_sel(s_sh_sel),
		.s_sh_we(s_sh_we), .s_sh_wdata(s_sh_wdata), .s_sh_grant(s_sh_grant),
		.s_sh_rvalid(s_sh_rvalid), .s_sh_rdata(s_sh_rdata),
		.bus_valid(bus_valid), .bus_ready(bus_ready), .bus_addr(bus_addr),
		.bus_sel(bus_sel), .bus_we(bus_we), .bus_wdata(bus_wdata),
		.bus_cpu(bus_cpu), .bus_rdata(bus_rdata)
	);

endmodule

//--- sim/bus86_props.sv
`timescale 1ns/10ps

module bus86_props import bus86_pkg::*; (
	input logic     clk_6m,
	input logic     rst_n,
	input logic     bus_valid,
	input logic     bus_ready,
	input logic     bus_cpu,
	input bus_sel_e bus_sel
);

	// Count of failed assertions
	int   fail_cnt = 0;
	logic phase;

	// 2H phase kept apart from the arbiter, master first after reset
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n)
			phase <= 1'b0;
		else
			phase <= !phase;
	end

	// A transfer always carries a real chip select
	a_sel_known: assert property (@(posedge clk_6m) disable iff (!rst_n)
		bus_valid |-> bus_sel != SEL_NONE)
		else begin
			$error("bus_valid high with SEL_NONE");
			fail_cnt++;
		end

	// Only the slot owner drives the bus
	a_slot_owner: assert property (@(posedge clk_6m) disable iff (!rst_n)
		bus_valid |-> bus_cpu == phase)
		else begin
			$error("bus_cpu differs from the current slot");
			fail_cnt++;
		end

	// A stalled request comes back in its owner's next slot, two clocks on
	a_stall_hold: assert property (@(posedge clk_6m) disable iff (!rst_n)
		bus_valid && !bus_ready |-> ##2 (bus_valid && bus_cpu == $past(bus_cpu, 2)
			&& bus_sel == $past(bus_sel, 2)))
		else begin
			$error("stalled bus request changed or vanished");
			fail_cnt++;
		end

	a_reset_idle: assert property (@(posedge clk_6m)
		!rst_n |-> !bus_valid)
		else begin
			$error("bus_valid high during reset");
			fail_cnt++;
		end

endmodule

bind slot_arbiter bus86_props props0 (
	.clk_6m(clk_6m),
	.rst_n(rst_n),
	.bus_valid(bus_valid),
	.bus_ready(bus_ready),
	.bus_cpu(bus_cpu),
	.bus_sel(bus_sel)
);

//--- sim/bus86_tb.sv
`timescale 1ns/10ps

module bus86_tb import bus86_pkg::*; ();

	localparam int N_REQ          = 300;
	localparam int TIMEOUT_CYCLES = 2 * N_REQ * 40;
	localparam int R_SH           = 0;
	localparam int R_LOC          = 1;
	localparam int R_ROM          = 2;

	logic            clk_6m;
	logic            rst_n;
	logic            vblank_n;

	// Index 0 is the master, index 1 the sub
	logic [1:0]      req_valid;
	logic [1:0]      req_ready;
	cpu_addr_t [1:0] req_addr;
	logic [1:0]      req_we;
	cpu_data_t [1:0] req_wdata;
	logic [1:0]      resp_valid;
	cpu_data_t [1:0] resp_rdata;
	logic [1:0]      rom_en;
	rom_addr_t [1:0] rom_addr;
	cpu_data_t [1:0] rom_data;
	logic            mrom_bank;

	logic            bus_valid;
	logic            bus_ready;
	bus_addr_t       bus_addr;
	bus_sel_e        bus_sel;
	logic            bus_we;
	cpu_data_t       bus_wdata;
	logic            bus_cpu;
	cpu_data_t       bus_rdata;
	logic            irq_m;
	logic            irq_s;
	cpu_data_t       backcolor;

	integer          seed;
	int              cyc;
	int              val_errs;
	int              proto_errs;
	cpu_data_t       vmem [0:65535];

	// Scoreboard, one outstanding request per CPU
	logic            busy [2];
	int              acc_cyc [2];
	logic            hs_done [2];
	int              hs_cyc [2];
	cpu_addr_t       sb_addr [2];
	logic            sb_we [2];
	cpu_data_t       sb_wdata [2];
	cpu_data_t       sb_exp [2];
	int              done_cnt [2];

	logic            taken [2];
	int              gap [2];
	int              issued [2];

	logic            model_bank;
	cpu_data_t       model_backcolor;
	logic            model_irq [2];
	logic            vb_last;
	int              vb_timer;
	logic            slot_exp;
	logic            rom_hit [2];
	cpu_data_t       rom_next [2];
	logic            rd_hit;
	cpu_data_t       rd_next;

	bus86_top dut0 (
		.clk_6m(clk_6m), .rst_n(rst_n), .vblank_n(vblank_n),
		.m_req_valid(req_valid[0]), .m_req_ready(req_ready[0]), .m_req_addr(req_addr[0]),
		.m_req_we(req_we[0]), .m_req_wdata(req_wdata[0]),
		.m_resp_valid(resp_valid[0]), .m_resp_rdata(resp_rdata[0]),
		.s_req_valid(req_valid[1]), .s_req_ready(req_ready[1]), .s_req_addr(req_addr[1]),
		.s_req_we(req_we[1]), .s_req_wdata(req_wdata[1]),
		.s_resp_valid(resp_valid[1]), .s_resp_rdata(resp_rdata[1]),
		.mrom_en(rom_en[0]), .mrom_addr(rom_addr[0]), .mrom_bank(mrom_bank),
		.mrom_data(rom_data[0]),
		.srom_en(rom_en[1]), .srom_addr(rom_addr[1]), .srom_data(rom_data[1]),
		.bus_valid(bus_valid), .bus_ready(bus_ready), .bus_addr(bus_addr),
		.bus_sel(bus_sel), .bus_we(bus_we), .bus_wdata(bus_wdata),
		.bus_cpu(bus_cpu), .bus_rdata(bus_rdata),
		.irq_m(irq_m), .irq_s(irq_s), .backcolor(backcolor)
	);

	always #4 clk_6m = ~clk_6m;

	always @(posedge clk_6m)
		if (rst_n)
			cyc <= cyc + 1;

	////////////////////////////////////////////////////////////////////////////
	// Memory map and models
	////////////////////////////////////////////////////////////////////////////

	function automatic int unsigned roll(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic int region_of(input cpu_addr_t a);
		if (a >= 16'h8000)
			return R_ROM;
		else if (a >= 16'h7000)
			return R_LOC;
		return R_SH;
	endfunction

	function automatic bus_sel_e sel_of(input cpu_addr_t a);
		if (a < 16'h2000)
			return SEL_SCROLL0;
		else if (a < 16'h4000)
			return SEL_SCROLL1;
		else if (a < 16'h6000)
			return SEL_OBJECT;
		else if (a < 16'h6800)
			return SEL_LATCH0;
		else if (a < 16'h7000)
			return SEL_LATCH1;
		return SEL_NONE;
	endfunction

	// ROM contents, tag 1 marks the sub ROM
	function automatic cpu_data_t rom_byte(input logic tag, input logic bank, input rom_addr_t a);
		return a[7:0] ^ {a[14:8], bank} ^ (tag ? 8'h5a : 8'ha5);
	endfunction

	function automatic string pfx(input int cpu);
		return (cpu == 1) ? "s_" : "m_";
	endfunction

	// Mostly shared windows, a small spread so reads hit earlier writes
	function automatic cpu_addr_t pick_addr();
		cpu_addr_t a;
		int unsigned kind;
		kind = roll(16);
		if (kind < 8) begin
			case (roll(5))
				0: a = 16'h0000;
				1: a = 16'h2000;
				2: a = 16'h4000;
				3: a = 16'h6000;
				default: a = 16'h6800;
			endcase
			a = a + cpu_addr_t'(roll(32));
		end else if (kind < 12) begin
			case (roll(4))
				0: a = 16'h7000 | OFS_BANK;
				1: a = 16'h7000 | OFS_BACKCOLOR;
				2: a = 16'h7000 | OFS_IRQ_ACK;
				default: a = 16'h7000 | cpu_addr_t'(roll(4096));
			endcase
		end else begin
			a = 16'h8000 | cpu_addr_t'(roll(32768));
		end
		return a;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_byte(input string name, input cpu_data_t exp, input cpu_data_t act);
		if (act !== exp) begin
			$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_sel(input string name, input bus_sel_e exp, input bus_sel_e act);
		if (act !== exp) begin
			$display("CHECK FAILED t=%0t %s expected %0d actual %0d", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_addr(input string name, input bus_addr_t exp, input bus_addr_t act);
		if (act !== exp) begin
			$display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, exp, act);
			val_errs++;
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("CHECK FAILED t=%0t %s expected %b actual %b", $time, name, exp, act);
			val_errs++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Scoreboard steps, run mid-cycle
	////////////////////////////////////////////////////////////////////////////

	task automatic step_irq();
		logic vfall;
		logic ack;
		check_bit("irq_m", model_irq[0], irq_m);
		check_bit("irq_s", model_irq[1], irq_s);
		vfall = vb_last && !vblank_n;
		for (int c = 0; c < 2; c++) begin
			// The ack write lands at the close of the local access cycle
			ack = busy[c] && region_of(sb_addr[c]) == R_LOC && sb_we[c]
				&& sb_addr[c][11:0] == OFS_IRQ_ACK && cyc == acc_cyc[c] + 1;
			if (vfall)
				model_irq[c] = 1'b1;
			else if (ack)
				model_irq[c] = 1'b0;
		end
		vb_last = vblank_n;
	endtask

	task automatic take_handshake(input int cpu);
		if (!busy[cpu] || region_of(sb_addr[cpu]) != R_SH || hs_done[cpu]) begin
			$display("Bus transfer at t=%0t in the %s slot with no shared request pending",
				$time, (cpu == 1) ? "sub" : "master");
			proto_errs++;
		end else begin
			check_sel("bus_sel", sel_of(sb_addr[cpu]), bus_sel);
			check_addr("bus_addr", sb_addr[cpu][12:0], bus_addr);
			check_bit("bus_we", sb_we[cpu], bus_we);
			if (sb_we[cpu])
				check_byte("bus_wdata", sb_wdata[cpu], bus_wdata);
			else
				sb_exp[cpu] = vmem[{sel_of(sb_addr[cpu]), sb_addr[cpu][12:0]}];
			hs_done[cpu] = 1'b1;
			hs_cyc[cpu]  = cyc;
		end
	endtask

	task automatic check_bus();
		logic      exp_valid;
		logic [15:0] idx;
		exp_valid = busy[slot_exp] && region_of(sb_addr[slot_exp]) == R_SH
			&& !hs_done[slot_exp] && cyc > acc_cyc[slot_exp];
		check_bit("bus_valid", exp_valid, bus_valid);
		if (bus_valid)
			check_bit("bus_cpu", slot_exp, bus_cpu);
		rd_hit = 1'b0;
		if (bus_valid && bus_ready) begin
			take_handshake(slot_exp ? 1 : 0);
			// Video memory as seen from the bus itself
			idx = {bus_sel, bus_addr};
			if (bus_we) begin
				vmem[idx] = bus_wdata;
			end else begin
				rd_hit  = 1'b1;
				rd_next = vmem[idx];
			end
		end
	endtask

	task automatic check_rom();
		logic exp_en;
		for (int c = 0; c < 2; c++) begin
			exp_en = busy[c] && region_of(sb_addr[c]) == R_ROM && !sb_we[c]
				&& cyc == acc_cyc[c] + 1;
			check_bit({pfx(c), "rom_en"}, exp_en, rom_en[c]);
			rom_hit[c] = rom_en[c];
		end
		rom_next[0] = rom_byte(1'b0, mrom_bank, rom_addr[0]);
		rom_next[1] = rom_byte(1'b1, 1'b0, rom_addr[1]);
	endtask

	task automatic check_response(input int cpu);
		logic exp_valid;
		int   rgn;
		exp_valid = 1'b0;
		rgn = region_of(sb_addr[cpu]);
		if (busy[cpu]) begin
			if (rgn == R_LOC)
				exp_valid = (cyc == acc_cyc[cpu] + 2);
			else if (rgn == R_ROM)
				exp_valid = (cyc == acc_cyc[cpu] + 3);
			else
				exp_valid = hs_done[cpu] && (cyc == hs_cyc[cpu] + (sb_we[cpu] ? 1 : 3));
		end
		if (exp_valid && !resp_valid[cpu]) begin
			$display("No response from the %s port at t=%0t for address %h",
				(cpu == 1) ? "sub" : "master", $time, sb_addr[cpu]);
			proto_errs++;
		end else begin
			check_bit({pfx(cpu), "resp_valid"}, exp_valid, resp_valid[cpu]);
		end
		if (exp_valid) begin
			if (resp_valid[cpu])
				check_byte({pfx(cpu), "resp_rdata"}, sb_exp[cpu], resp_rdata[cpu]);
			// Only the master reaches bank and back colour
			if (cpu == 0 && rgn == R_LOC && sb_we[cpu]) begin
				if (sb_addr[cpu][11:0] == OFS_BANK)
					model_bank = sb_wdata[cpu][0];
				else if (sb_addr[cpu][11:0] == OFS_BACKCOLOR)
					model_backcolor = sb_wdata[cpu];
			end
			busy[cpu] = 1'b0;
			done_cnt[cpu]++;
		end
	endtask

	task automatic take_request(input int cpu);
		int rgn;
		check_bit({pfx(cpu), "req_ready"}, !busy[cpu], req_ready[cpu]);
		if (req_valid[cpu] && req_ready[cpu]) begin
			rgn           = region_of(req_addr[cpu]);
			busy[cpu]     = 1'b1;
			acc_cyc[cpu]  = cyc;
			sb_addr[cpu]  = req_addr[cpu];
			sb_we[cpu]    = req_we[cpu];
			sb_wdata[cpu] = req_wdata[cpu];
			hs_done[cpu]  = 1'b0;
			taken[cpu]    = 1'b1;
			sb_exp[cpu]   = '0;
			if (!req_we[cpu] && rgn == R_ROM) begin
				sb_exp[cpu] = rom_byte(cpu == 1, (cpu == 0) ? model_bank : 1'b0,
					req_addr[cpu][14:0]);
			end else if (!req_we[cpu] && rgn == R_LOC && cpu == 0) begin
				if (req_addr[cpu][11:0] == OFS_BANK)
					sb_exp[cpu] = {7'd0, model_bank};
				else if (req_addr[cpu][11:0] == OFS_BACKCOLOR)
					sb_exp[cpu] = model_backcolor;
			end
		end
	endtask

	always @(negedge clk_6m) begin
		if (rst_n) begin
			step_irq();
			check_bus();
			check_rom();
			check_response(0);
			check_response(1);
			check_bit("mrom_bank", model_bank, mrom_bank);
			check_byte("backcolor", model_backcolor, backcolor);
			take_request(0);
			take_request(1);
			slot_exp = !slot_exp;
		end else begin
			check_bit("bus_valid", 1'b0, bus_valid);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus, driven 1 ns after the rising edge
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_cpu(input int cpu);
		if (taken[cpu]) begin
			taken[cpu]     = 1'b0;
			req_valid[cpu] = 1'b0;
			gap[cpu]       = roll(4);
		end else if (!req_valid[cpu]) begin
			if (gap[cpu] > 0) begin
				gap[cpu]--;
			end else if (issued[cpu] < N_REQ) begin
				req_valid[cpu] = 1'b1;
				req_addr[cpu]  = pick_addr();
				req_we[cpu]    = (roll(2) == 1);
				req_wdata[cpu] = cpu_data_t'(roll(256));
				issued[cpu]++;
			end
		end
	endtask

	task automatic drive_models();
		bus_ready = (roll(10) < 7);
		bus_rdata = rd_hit ? rd_next : cpu_data_t'(roll(256));
		for (int c = 0; c < 2; c++)
			rom_data[c] = rom_hit[c] ? rom_next[c] : cpu_data_t'(roll(256));
		// Long active video, short blanking
		if (vb_timer == 0) begin
			vblank_n = !vblank_n;
			vb_timer = vblank_n ? 150 + roll(100) : 8 + roll(16);
		end else begin
			vb_timer--;
		end
	endtask

	initial begin
		seed      = 32'h8baf_f2fa;
		clk_6m    = 1'b0;
		rst_n     = 1'b1;
		vblank_n  = 1'b1;
		req_valid = '0;
		req_addr  = '0;
		req_we    = '0;
		req_wdata = '0;
		rom_data  = '0;
		bus_ready = 1'b0;
		bus_rdata = '0;
		cyc        = 0;
		val_errs   = 0;
		proto_errs = 0;
		for (int c = 0; c < 2; c++) begin
			busy[c]      = 1'b0;
			acc_cyc[c]   = 0;
			hs_done[c]   = 1'b0;
			hs_cyc[c]    = 0;
			sb_addr[c]   = '0;
			sb_we[c]     = 1'b0;
			sb_wdata[c]  = '0;
			sb_exp[c]    = '0;
			done_cnt[c]  = 0;
			taken[c]     = 1'b0;
			gap[c]       = 0;
			issued[c]    = 0;
			model_irq[c] = 1'b0;
			rom_hit[c]   = 1'b0;
			rom_next[c]  = '0;
		end
		model_bank      = 1'b0;
		model_backcolor = '0;
		vb_last         = 1'b1;
		vb_timer        = 100;
		slot_exp        = 1'b0;
		rd_hit          = 1'b0;
		rd_next         = '0;
		for (int i = 0; i < 65536; i++)
			vmem[i] = cpu_data_t'(i[7:0] ^ i[15:8]);

		#1 rst_n = 1'b0;
		repeat (5) @(posedge clk_6m);
		#1 rst_n = 1'b1;

		while (done_cnt[0] < N_REQ || done_cnt[1] < N_REQ) begin
			@(posedge clk_6m);
			#1;
			drive_cpu(0);
			drive_cpu(1);
			drive_models();
		end
		repeat (4) @(posedge clk_6m);

		$display("Errors: %0d value, %0d protocol, %0d assertion; responses %0d/%0d",
			val_errs, proto_errs, dut0.arb0.props0.fail_cnt, done_cnt[0], done_cnt[1]);
		if (val_errs + proto_errs + dut0.arb0.props0.fail_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		wait (cyc >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles: %0d value, %0d protocol errors, %0d/%0d responses",
			cyc, val_errs, proto_errs, done_cnt[0], done_cnt[1]);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- bus86.f
logic/bus86_pkg.sv
logic/cpu_port.sv
logic/ctrl_regs.sv
logic/slot_arbiter.sv
logic/bus86_top.sv
sim/bus86_props.sv
sim/bus86_tb.sv

//--- Bender.yml
package:
  name: bus86

sources:
  - logic/bus86_pkg.sv
  - logic/cpu_port.sv
  - logic/ctrl_regs.sv
  - logic/slot_arbiter.sv
  - logic/bus86_top.sv
  - target: simulation
    files:
      - sim/bus86_props.sv
      - sim/bus86_tb.sv
